/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_csrng_top
FILELIST  := compile.f
OBJDIR    := obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* compile.f */
+incdir+test
src/csrng_pkg.sv
src/csrng_arb_if.sv
src/csrng_fifo_sync.sv
src/csrng_cmd_stage.sv
src/csrng_cmd_arb.sv
src/csrng_core_lite.sv
src/csrng_top.sv
test/tb_csrng_top.sv

/* src/csrng_arb_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Link between one staging block and the shared arbiter.
interface csrng_arb_if;

  logic                      req;
  logic                      sop;
  logic                      mop;
  logic                      eop;
  logic [csrng_pkg::CmdW-1:0] bus;
  logic                      gnt;

  modport stage (
    output req, sop, mop, eop, bus,
    input  gnt
  );

  modport arb (
    input  req, sop, mop, eop, bus,
    output gnt
  );

endinterface

`default_nettype wire

/* src/csrng_cmd_arb.sv */
`timescale 1ns/1ps
`default_nettype none

module csrng_cmd_arb (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  csrng_arb_if.arb                     stg [csrng_pkg::NumApps],
  output logic                         core_vld_o,
  output logic                         core_sop_o,
  output logic                         core_eop_o,
  output logic [csrng_pkg::CmdW-1:0]   core_bus_o,
  output logic [csrng_pkg::AppIdW-1:0] core_app_o
);

  localparam int unsigned NumApps = csrng_pkg::NumApps;
  localparam int unsigned AppIdW  = csrng_pkg::AppIdW;

  logic [NumApps-1:0]         req;
  logic [NumApps-1:0]         sop;
  logic [NumApps-1:0]         mop;
  logic [NumApps-1:0]         eop;
  logic [NumApps-1:0]         gnt;
  logic [csrng_pkg::CmdW-1:0] bus [NumApps];
  logic                       lock_q;
  logic [AppIdW-1:0]          owner_q;
  logic [AppIdW-1:0]          prio_q;
  logic                       win_vld;
  logic [AppIdW-1:0]          win;

  for (genvar i = 0; i < NumApps; i++) begin : g_link
    assign req[i]     = stg[i].req;
    assign sop[i]     = stg[i].sop;
    assign mop[i]     = stg[i].mop;
    assign eop[i]     = stg[i].eop;
    assign bus[i]     = stg[i].bus;
    assign stg[i].gnt = gnt[i];
  end

  // Round robin, starting at the priority pointer.
  always_comb begin : p_pick
    int unsigned idx;
    win_vld = 1'b0;
    win     = '0;
    for (int k = NumApps - 1; k >= 0; k--) begin
      idx = (int'(prio_q) + k) % NumApps;
      if (req[idx]) begin
        win_vld = 1'b1;
        win     = AppIdW'(idx);
      end
    end
  end

  always_comb begin
    gnt = '0;
    if (lock_q) begin
      gnt[owner_q] = req[owner_q];
    end else if (win_vld) begin
      gnt[win] = 1'b1;
    end
  end

  // Words pass only from the locked stage.
  assign core_vld_o = lock_q && (sop[owner_q] || mop[owner_q]);
  assign core_sop_o = lock_q && sop[owner_q];
  assign core_eop_o = lock_q && eop[owner_q];
  assign core_bus_o = bus[owner_q];
  assign core_app_o = owner_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q  <= 1'b0;
      owner_q <= '0;
      prio_q  <= '0;
    end else if (lock_q) begin
      // A stage that drops req has been aborted.
      if (core_eop_o || !req[owner_q]) begin
        lock_q <= 1'b0;
        prio_q <= (owner_q == AppIdW'(NumApps - 1)) ? '0 : owner_q + 1'b1;
      end
    end else if (win_vld) begin
      lock_q  <= 1'b1;
      owner_q <= win;
    end
  end

endmodule

`default_nettype wire

/* src/csrng_cmd_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module csrng_cmd_stage (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       enable_i,
  // Application command port.
  input  logic                       cmd_vld_i,
  input  logic [csrng_pkg::CmdW-1:0] cmd_bus_i,
  output logic                       cmd_rdy_o,
  output logic                       cmd_ack_o,
  output logic                       cmd_ack_sts_o,
  // Arbiter link.
  csrng_arb_if.stage                 arb,
  // Core results for this port.
  input  logic                       core_ack_i,
  input  logic                       core_ack_sts_i,
  input  logic                       core_genbits_vld_i,
  input  csrng_pkg::genbits_t        core_genbits_i,
  // Application genbits port.
  output logic                       genbits_vld_o,
  input  logic                       genbits_rdy_i,
  output logic [csrng_pkg::BlockW-1:0] genbits_bus_o,
  output logic                       genbits_fips_o,
  output logic [5:0]                 fifo_err_o
);

  localparam int unsigned ClenW = csrng_pkg::ClenMsb - csrng_pkg::ClenLsb + 1;

  typedef enum logic [2:0] {
    Idle, ArbGnt, SendSop, SendMop, CmdAck, GenReq, GenArbGnt, GenSop
  } state_e;

  state_e                           state_q, state_d;
  logic [csrng_pkg::CmdW-1:0]       cmd_rdata;
  logic                             cmd_wready;
  logic                             cmd_nonempty;
  logic                             cmd_pop;
  logic [2:0]                       cmd_err;
  csrng_pkg::genbits_t              gb_rdata;
  logic                             gb_nonempty;
  logic                             gb_full;
  logic [2:0]                       gb_err;
  logic [ClenW-1:0]                 clen_q;
  logic                             gen_q;
  logic [csrng_pkg::FlagsMsb:0]     hdr_q;
  logic [csrng_pkg::GenCntW-1:0]    cnt_q;
  logic                             core_sts_q;
  logic                             ack_q;
  logic                             ack_sts_q;
  logic [csrng_pkg::GenCntW-1:0]    glen;
  logic                             is_gen;
  logic                             load;
  logic                             dec;
  logic                             glast;
  logic                             final_ack;

  // ------------------------------
  // Command FIFO.
  // ------------------------------
  csrng_fifo_sync #(
    .T     (logic [csrng_pkg::CmdW-1:0]),
    .Depth (csrng_pkg::CmdFifoDepth)
  ) u_fifo_cmd (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clr_i    (!enable_i),
    .wvalid_i (cmd_vld_i && cmd_rdy_o),
    .wready_o (cmd_wready),
    .wdata_i  (cmd_bus_i),
    .rvalid_o (cmd_nonempty),
    .rready_i (cmd_pop),
    .rdata_o  (cmd_rdata),
    .full_o   (),
    .err_o    (cmd_err)
  );

  assign cmd_rdy_o = enable_i && cmd_wready;

  // A generate with zero blocks runs as a plain command.
  assign glen   = cmd_rdata[csrng_pkg::GlenMsb:csrng_pkg::GlenLsb];
  assign is_gen = (cmd_rdata[csrng_pkg::AcmdMsb:csrng_pkg::AcmdLsb] == csrng_pkg::GEN) &&
                  (glen != '0);

  // ------------------------------
  // Packet FSM.
  // ------------------------------
  always_comb begin
    state_d   = state_q;
    cmd_pop   = 1'b0;
    load      = 1'b0;
    dec       = 1'b0;
    glast     = 1'b0;
    final_ack = 1'b0;
    arb.req   = 1'b0;
    arb.sop   = 1'b0;
    arb.mop   = 1'b0;
    arb.eop   = 1'b0;
    unique case (state_q)
      Idle: begin
        if (cmd_nonempty) begin
          state_d = ArbGnt;
        end
      end
      ArbGnt: begin
        arb.req = 1'b1;
        if (arb.gnt) begin
          state_d = SendSop;
        end
      end
      SendSop: begin
        // Req stays up so the arbiter keeps the lock until eop.
        arb.req = 1'b1;
        arb.sop = 1'b1;
        cmd_pop = 1'b1;
        load    = 1'b1;
        glast   = is_gen && (glen == csrng_pkg::GenCntW'(1));
        if (cmd_rdata[csrng_pkg::ClenMsb:csrng_pkg::ClenLsb] == '0) begin
          arb.eop = 1'b1;
          state_d = CmdAck;
        end else begin
          state_d = SendMop;
        end
      end
      SendMop: begin
        arb.req = 1'b1;
        if (cmd_nonempty) begin
          cmd_pop = 1'b1;
          arb.mop = 1'b1;
          if (clen_q == ClenW'(1)) begin
            arb.eop = 1'b1;
            state_d = CmdAck;
          end
        end
      end
      CmdAck: begin
        if (core_ack_i) begin
          state_d = GenReq;
        end
      end
      GenReq: begin
        if (!gen_q) begin
          final_ack = 1'b1;
          state_d   = Idle;
        end else if (!gb_full) begin
          // Wait here until the application has taken the last block.
          if (cnt_q == '0) begin
            final_ack = 1'b1;
            state_d   = Idle;
          end else begin
            state_d = GenArbGnt;
          end
        end
      end
      GenArbGnt: begin
        arb.req = 1'b1;
        if (arb.gnt) begin
          state_d = GenSop;
        end
      end
      GenSop: begin
        arb.req = 1'b1;
        arb.sop = 1'b1;
        arb.eop = 1'b1;
        dec     = 1'b1;
        glast   = (cnt_q == csrng_pkg::GenCntW'(1));
        state_d = CmdAck;
      end
      default: state_d = Idle;
    endcase
  end

  // Header words on the link, follow-on generate headers are rebuilt.
  always_comb begin
    arb.bus = cmd_rdata;
    if (state_q == SendSop) begin
      arb.bus = '0;
      arb.bus[csrng_pkg::GlenMsb:0] = cmd_rdata[csrng_pkg::GlenMsb:0];
      arb.bus[csrng_pkg::GlastBit]  = glast;
    end else if (state_q == GenSop) begin
      arb.bus = '0;
      arb.bus[csrng_pkg::GlenMsb:csrng_pkg::GlenLsb]   = cnt_q;
      arb.bus[csrng_pkg::FlagsMsb:csrng_pkg::FlagsLsb] =
          hdr_q[csrng_pkg::FlagsMsb:csrng_pkg::FlagsLsb];
      arb.bus[csrng_pkg::AcmdMsb:csrng_pkg::AcmdLsb]   =
          hdr_q[csrng_pkg::AcmdMsb:csrng_pkg::AcmdLsb];
      arb.bus[csrng_pkg::GlastBit] = glast;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      clen_q     <= '0;
      gen_q      <= 1'b0;
      cnt_q      <= '0;
      core_sts_q <= 1'b0;
      ack_q      <= 1'b0;
      ack_sts_q  <= 1'b0;
    end else if (!enable_i) begin
      state_q <= Idle;
      clen_q  <= '0;
      gen_q   <= 1'b0;
      cnt_q   <= '0;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= final_ack;
      if (load) begin
        clen_q <= cmd_rdata[csrng_pkg::ClenMsb:csrng_pkg::ClenLsb];
        gen_q  <= is_gen;
        cnt_q  <= is_gen ? glen - 1'b1 : '0;
      end else if (arb.mop) begin
        clen_q <= clen_q - 1'b1;
      end
      if (dec) begin
        cnt_q <= cnt_q - 1'b1;
      end
      if ((state_q == CmdAck) && core_ack_i) begin
        core_sts_q <= core_ack_sts_i;
      end
      if (final_ack) begin
        ack_sts_q <= core_sts_q;
      end
    end
  end

  // Low header bits, kept for follow-on requests.
  always_ff @(posedge clk_i) begin
    if (load) begin
      hdr_q <= cmd_rdata[csrng_pkg::FlagsMsb:0];
    end
  end

  assign cmd_ack_o     = ack_q;
  assign cmd_ack_sts_o = ack_sts_q;

  // ------------------------------
  // Genbits buffer.
  // ------------------------------
  csrng_fifo_sync #(
    .T     (csrng_pkg::genbits_t),
    .Depth (csrng_pkg::GenFifoDepth)
  ) u_fifo_genbits (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clr_i    (!enable_i),
    .wvalid_i (enable_i && core_genbits_vld_i),
    .wready_o (),
    .wdata_i  (core_genbits_i),
    .rvalid_o (gb_nonempty),
    .rready_i (genbits_vld_o && genbits_rdy_i),
    .rdata_o  (gb_rdata),
    .full_o   (gb_full),
    .err_o    (gb_err)
  );

  assign genbits_vld_o  = enable_i && gb_nonempty;
  assign genbits_bus_o  = gb_rdata.bits;
  assign genbits_fips_o = gb_rdata.fips;
  assign fifo_err_o     = {gb_err, cmd_err};

endmodule

`default_nettype wire

/* src/csrng_core_lite.sv */
`timescale 1ns/1ps
`default_nettype none

module csrng_core_lite (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         enable_i,
  input  logic                         cmd_vld_i,
  input  logic                         cmd_sop_i,
  input  logic                         cmd_eop_i,
  input  logic [csrng_pkg::CmdW-1:0]   cmd_bus_i,
  input  logic [csrng_pkg::AppIdW-1:0] cmd_app_i,
  output logic                         ack_o,
  output logic                         ack_sts_o,
  output logic [csrng_pkg::AppIdW-1:0] ack_app_o,
  output logic                         genbits_vld_o,
  output csrng_pkg::genbits_t          genbits_o
);

  localparam int unsigned NumApps = csrng_pkg::NumApps;
  localparam int unsigned CmdW    = csrng_pkg::CmdW;

  logic [CmdW-1:0]              v_q [NumApps];
  logic [CmdW-1:0]              v_d [NumApps];
  logic [NumApps-1:0]           inst_q;
  logic [NumApps-1:0]           inst_d;
  csrng_pkg::acmd_e             acmd_q;
  logic                         glen_nz_q;
  logic [csrng_pkg::AppIdW-1:0] app_q;
  logic [CmdW-1:0]              acc_q;
  logic                         exec_q;
  logic [CmdW-1:0]              v_cur;
  logic                         sts_d;
  logic                         gen_d;

  // Packet capture; header on sop, XOR of the rest.
  always_ff @(posedge clk_i) begin
    if (cmd_vld_i) begin
      if (cmd_sop_i) begin
        acmd_q    <= csrng_pkg::acmd_e'(cmd_bus_i[csrng_pkg::AcmdMsb:csrng_pkg::AcmdLsb]);
        glen_nz_q <= (cmd_bus_i[csrng_pkg::GlenMsb:csrng_pkg::GlenLsb] != '0);
        app_q     <= cmd_app_i;
        acc_q     <= '0;
      end else begin
        acc_q <= acc_q ^ cmd_bus_i;
      end
    end
  end

  assign v_cur = v_q[app_q];

  // ------------------------------
  // Generator rule.
  // ------------------------------
  always_comb begin
    v_d    = v_q;
    inst_d = inst_q;
    sts_d  = 1'b0;
    gen_d  = 1'b0;
    case (acmd_q)
      csrng_pkg::INS, csrng_pkg::RES: begin
        v_d[app_q]    = acc_q;
        inst_d[app_q] = 1'b1;
      end
      csrng_pkg::UPD: begin
        if (inst_q[app_q]) begin
          v_d[app_q] = v_cur ^ acc_q;
        end else begin
          sts_d = 1'b1;
        end
      end
      csrng_pkg::UNI: begin
        v_d[app_q]    = '0;
        inst_d[app_q] = 1'b0;
      end
      csrng_pkg::GEN: begin
        // Zero length acks with no block.
        if (glen_nz_q) begin
          gen_d      = 1'b1;
          sts_d      = !inst_q[app_q];
          v_d[app_q] = v_cur + 1'b1;
        end
      end
      default: sts_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      v_q           <= '{default: '0};
      inst_q        <= '0;
      exec_q        <= 1'b0;
      ack_o         <= 1'b0;
      ack_sts_o     <= 1'b0;
      ack_app_o     <= '0;
      genbits_vld_o <= 1'b0;
    end else begin
      exec_q        <= enable_i && cmd_vld_i && cmd_eop_i;
      ack_o         <= enable_i && exec_q;
      genbits_vld_o <= enable_i && exec_q && gen_d;
      if (enable_i && exec_q) begin
        v_q       <= v_d;
        inst_q    <= inst_d;
        ack_sts_o <= sts_d;
        ack_app_o <= app_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (exec_q && gen_d) begin
      genbits_o.bits <= {v_cur ^ csrng_pkg::GenK3, v_cur ^ csrng_pkg::GenK2,
                         v_cur ^ csrng_pkg::GenK1, v_cur};
      genbits_o.fips <= inst_q[app_q];
    end
  end

endmodule

`default_nettype wire

/* src/csrng_fifo_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module csrng_fifo_sync #(
  parameter type         T     = logic [31:0],
  parameter int unsigned Depth = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clr_i,
  input  logic       wvalid_i,
  output logic       wready_o,
  input  T           wdata_i,
  output logic       rvalid_o,
  input  logic       rready_i,
  output T           rdata_o,
  output logic       full_o,
  output logic [2:0] err_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  T                mem [Depth];
  logic [PtrW-1:0] wptr_q;
  logic [PtrW-1:0] rptr_q;
  logic [CntW-1:0] cnt_q;
  logic            push;
  logic            pop;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o   = (cnt_q == CntW'(Depth));
  assign rvalid_o = (cnt_q != '0);
  assign wready_o = !full_o;
  assign push     = wvalid_i && wready_o;
  assign pop      = rready_i && rvalid_o;
  assign rdata_o  = mem[rptr_q];

  // Push while full, pop while empty, full and empty together.
  assign err_o = {wvalid_i && full_o, rready_i && !rvalid_o, full_o && !rvalid_o};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else if (clr_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (pop) begin
        rptr_q <= ptr_inc(rptr_q);
      end
      cnt_q <= cnt_q + CntW'(push) - CntW'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

/* src/csrng_pkg.sv */
`default_nettype none

package csrng_pkg;

  // Sizes.
  localparam int unsigned NumApps      = 2;
  localparam int unsigned AppIdW       = 1;
  localparam int unsigned CmdW         = 32;
  localparam int unsigned CmdFifoDepth = 16;
  localparam int unsigned GenFifoDepth = 1;
  localparam int unsigned GenCntW      = 13;
  localparam int unsigned BlockW       = 128;

  // Application command codes.
  // Codes 0, 6 and 7 are illegal.
  typedef enum logic [2:0] {
    INS = 3'd1,
    RES = 3'd2,
    GEN = 3'd3,
    UPD = 3'd4,
    UNI = 3'd5
  } acmd_e;

  // ------------------------------
  // Header field positions.
  // ------------------------------
  localparam int unsigned AcmdLsb  = 0;
  localparam int unsigned AcmdMsb  = 2;
  localparam int unsigned ClenLsb  = 4;
  localparam int unsigned ClenMsb  = 7;
  localparam int unsigned FlagsLsb = 8;
  localparam int unsigned FlagsMsb = 11;
  localparam int unsigned GlenLsb  = 12;
  localparam int unsigned GlenMsb  = 24;
  localparam int unsigned GlastBit = 25;

  // One block of random bits with its fips flag.
  typedef struct packed {
    logic              fips;
    logic [BlockW-1:0] bits;
  } genbits_t;

  // Word masks for the stand-in generator.
  localparam logic [CmdW-1:0] GenK1 = 32'h9e37_79b9;
  localparam logic [CmdW-1:0] GenK2 = 32'h7f4a_7c15;
  localparam logic [CmdW-1:0] GenK3 = 32'hc2b2_ae35;

endpackage

`default_nettype wire

/* src/csrng_top.sv */
`timescale 1ns/1ps
`default_nettype none

module csrng_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         enable_i,
  input  logic                         cmd_vld_i      [csrng_pkg::NumApps],
  input  logic [csrng_pkg::CmdW-1:0]   cmd_bus_i      [csrng_pkg::NumApps],
  output logic                         cmd_rdy_o      [csrng_pkg::NumApps],
  output logic                         cmd_ack_o      [csrng_pkg::NumApps],
  output logic                         cmd_ack_sts_o  [csrng_pkg::NumApps],
  output logic                         genbits_vld_o  [csrng_pkg::NumApps],
  input  logic                         genbits_rdy_i  [csrng_pkg::NumApps],
  output logic [csrng_pkg::BlockW-1:0] genbits_bus_o  [csrng_pkg::NumApps],
  output logic                         genbits_fips_o [csrng_pkg::NumApps],
  output logic [5:0]                   fifo_err_o     [csrng_pkg::NumApps]
);

  logic                         core_vld;
  logic                         core_sop;
  logic                         core_eop;
  logic [csrng_pkg::CmdW-1:0]   core_bus;
  logic [csrng_pkg::AppIdW-1:0] core_app;
  logic                         ack;
  logic                         ack_sts;
  logic [csrng_pkg::AppIdW-1:0] ack_app;
  logic                         gen_vld;
  csrng_pkg::genbits_t          genbits;

  csrng_arb_if arb_if [csrng_pkg::NumApps] ();

  for (genvar i = 0; i < csrng_pkg::NumApps; i++) begin : g_stage
    // Core results go to the port named by the ack.
    csrng_cmd_stage u_stage (
      .clk_i              (clk_i),
      .rst_ni             (rst_ni),
      .enable_i           (enable_i),
      .cmd_vld_i          (cmd_vld_i[i]),
      .cmd_bus_i          (cmd_bus_i[i]),
      .cmd_rdy_o          (cmd_rdy_o[i]),
      .cmd_ack_o          (cmd_ack_o[i]),
      .cmd_ack_sts_o      (cmd_ack_sts_o[i]),
      .arb                (arb_if[i]),
      .core_ack_i         (ack && (ack_app == csrng_pkg::AppIdW'(i))),
      .core_ack_sts_i     (ack_sts),
      .core_genbits_vld_i (gen_vld && (ack_app == csrng_pkg::AppIdW'(i))),
      .core_genbits_i     (genbits),
      .genbits_vld_o      (genbits_vld_o[i]),
      .genbits_rdy_i      (genbits_rdy_i[i]),
      .genbits_bus_o      (genbits_bus_o[i]),
      .genbits_fips_o     (genbits_fips_o[i]),
      .fifo_err_o         (fifo_err_o[i])
    );
  end

  csrng_cmd_arb u_arb (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .stg        (arb_if),
    .core_vld_o (core_vld),
    .core_sop_o (core_sop),
    .core_eop_o (core_eop),
    .core_bus_o (core_bus),
    .core_app_o (core_app)
  );

  csrng_core_lite u_core (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .enable_i      (enable_i),
    .cmd_vld_i     (core_vld),
    .cmd_sop_i     (core_sop),
    .cmd_eop_i     (core_eop),
    .cmd_bus_i     (core_bus),
    .cmd_app_i     (core_app),
    .ack_o         (ack),
    .ack_sts_o     (ack_sts),
    .ack_app_o     (ack_app),
    .genbits_vld_o (gen_vld),
    .genbits_o     (genbits)
  );

endmodule

`default_nettype wire

/* test/csrng_tb_model.svh */
`ifndef CSRNG_TB_MODEL_SVH
`define CSRNG_TB_MODEL_SVH

// Reference model of the per-application generator state.
// Expected results are queued per app in command order.

logic [31:0]  mdl_v      [NumApps];
logic         mdl_inst   [NumApps];
logic         exp_sts_q  [NumApps][$];
int           exp_mark_q [NumApps][$];
logic [128:0] exp_blk_q  [NumApps][$];
int           blk_issued [NumApps];
int           blk_seen   [NumApps];
int           cmds_issued;

function automatic void reset_model();
  for (int a = 0; a < NumApps; a++) begin
    mdl_v[a]      = '0;
    mdl_inst[a]   = 1'b0;
    blk_issued[a] = 0;
    blk_seen[a]   = 0;
  end
  cmds_issued = 0;
endfunction

// Applies one command to the app state and queues its results.
function automatic void expect_command(input int app, input logic [2:0] acmd,
                                       input logic [12:0] glen, input logic [31:0] wx);
  logic        sts;
  logic [31:0] v;
  sts = 1'b0;
  case (acmd)
    csrng_pkg::INS, csrng_pkg::RES: begin
      mdl_v[app]    = wx;
      mdl_inst[app] = 1'b1;
    end
    csrng_pkg::UPD: begin
      if (mdl_inst[app]) begin
        mdl_v[app] = mdl_v[app] ^ wx;
      end else begin
        sts = 1'b1;
      end
    end
    csrng_pkg::UNI: begin
      mdl_v[app]    = '0;
      mdl_inst[app] = 1'b0;
    end
    csrng_pkg::GEN: begin
      // One block per request, the state steps after each.
      for (int b = 0; b < int'(glen); b++) begin
        v = mdl_v[app];
        exp_blk_q[app].push_back({mdl_inst[app], v ^ csrng_pkg::GenK3,
                                  v ^ csrng_pkg::GenK2, v ^ csrng_pkg::GenK1, v});
        mdl_v[app]      = v + 32'd1;
        blk_issued[app] = blk_issued[app] + 1;
      end
      sts = (glen != '0) && !mdl_inst[app];
    end
    default: sts = 1'b1;
  endcase
  exp_sts_q[app].push_back(sts);
  exp_mark_q[app].push_back(blk_issued[app]);
  cmds_issued = cmds_issued + 1;
endfunction

`endif

/* test/tb_csrng_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_csrng_top;

  localparam int          NumApps     = csrng_pkg::NumApps;
  localparam int          ResetCycles = 10;
  localparam int          NumRandCmds = 40;
  localparam int          TotalCmds   = NumApps * (3 + NumRandCmds) + 7;
  localparam logic [31:0] Seed        = 32'h7d65_7def;

  logic         clk_i;
  logic         rst_ni;
  logic         enable_i;
  logic         cmd_vld_i      [NumApps];
  logic [31:0]  cmd_bus_i      [NumApps];
  logic         cmd_rdy_o      [NumApps];
  logic         cmd_ack_o      [NumApps];
  logic         cmd_ack_sts_o  [NumApps];
  logic         genbits_vld_o  [NumApps];
  logic         genbits_rdy_i  [NumApps];
  logic [127:0] genbits_bus_o  [NumApps];
  logic         genbits_fips_o [NumApps];
  logic [5:0]   fifo_err_o     [NumApps];

  logic [31:0]  rng_q    [2 * NumApps];
  logic         hold_rdy [NumApps];
  int           acks_seen;
  int           value_errs;
  int           other_errs;

  `include "csrng_tb_model.svh"

  csrng_top dut0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .enable_i       (enable_i),
    .cmd_vld_i      (cmd_vld_i),
    .cmd_bus_i      (cmd_bus_i),
    .cmd_rdy_o      (cmd_rdy_o),
    .cmd_ack_o      (cmd_ack_o),
    .cmd_ack_sts_o  (cmd_ack_sts_o),
    .genbits_vld_o  (genbits_vld_o),
    .genbits_rdy_i  (genbits_rdy_i),
    .genbits_bus_o  (genbits_bus_o),
    .genbits_fips_o (genbits_fips_o),
    .fifo_err_o     (fifo_err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ------------------------------
  // Helpers.
  // ------------------------------
  task automatic flag_mismatch(input string msg);
    value_errs++;
    $display("Fail at time %0t: %s", $time, msg);
  endtask

  task automatic flag_problem(input string msg);
    other_errs++;
    $display("Error at time %0t: %s", $time, msg);
  endtask

  // One LCG stream per driver.
  function automatic logic [31:0] lcg_next(input int stream);
    rng_q[stream] = rng_q[stream] * 32'd1664525 + 32'd1013904223;
    return rng_q[stream];
  endfunction

  function automatic logic [2:0] pick_code(input logic [3:0] sel);
    case (sel)
      4'd0, 4'd1, 4'd2:               return csrng_pkg::INS;
      4'd3:                           return csrng_pkg::RES;
      4'd4, 4'd5, 4'd6, 4'd7, 4'd8:   return csrng_pkg::GEN;
      4'd9, 4'd10:                    return csrng_pkg::UPD;
      4'd11:                          return csrng_pkg::UNI;
      4'd12:                          return 3'd0;
      4'd13:                          return 3'd6;
      4'd14:                          return 3'd7;
      default:                        return csrng_pkg::GEN;
    endcase
  endfunction

  // Starts and ends on a falling edge.
  task automatic push_word(input int app, input logic [31:0] word);
    cmd_vld_i[app] = 1'b1;
    cmd_bus_i[app] = word;
    @(posedge clk_i);
    while (!cmd_rdy_o[app]) @(posedge clk_i);
    @(negedge clk_i);
    cmd_vld_i[app] = 1'b0;
  endtask

  task automatic send_command(input int app, input logic [2:0] acmd,
                              input logic [3:0] clen, input logic [12:0] glen);
    logic [31:0] words [16];
    logic [31:0] hdr;
    logic [31:0] wx;
    logic [31:0] r;
    r   = lcg_next(app);
    hdr = {7'd0, glen, r[27:24], clen, 1'b0, acmd};
    wx  = '0;
    for (int i = 0; i < int'(clen); i++) begin
      words[i] = lcg_next(app);
      wx       = wx ^ words[i];
    end
    expect_command(app, acmd, glen, wx);
    push_word(app, hdr);
    for (int i = 0; i < int'(clen); i++) begin
      r = lcg_next(app);
      // Occasional gap inside the packet.
      if (r[31:29] == 3'd0) begin
        @(negedge clk_i);
      end
      push_word(app, words[i]);
    end
  endtask

  task automatic run_app(input int app);
    logic [31:0] r;
    // Uninstantiated cases first.
    send_command(app, csrng_pkg::GEN, 4'd0, 13'd2);
    send_command(app, csrng_pkg::UPD, 4'd1, 13'd0);
    send_command(app, csrng_pkg::GEN, 4'd0, 13'd0);
    for (int n = 0; n < NumRandCmds; n++) begin
      r = lcg_next(app);
      send_command(app, pick_code(r[31:28]), r[27:24], {11'd0, r[21:20]});
      repeat (int'(r[17:16])) @(negedge clk_i);
    end
  endtask

  task automatic drive_genbits_ready(input int app);
    logic [31:0] r;
    int          stall;
    stall = 0;
    forever begin
      @(negedge clk_i);
      r = lcg_next(NumApps + app);
      if (hold_rdy[app]) begin
        genbits_rdy_i[app] = 1'b0;
      end else if (stall > 0) begin
        stall--;
        genbits_rdy_i[app] = 1'b0;
      end else if (r[15:8] < 8'd4) begin
        stall              = 8 + int'(r[7:3]);
        genbits_rdy_i[app] = 1'b0;
      end else begin
        genbits_rdy_i[app] = (r[31:16] % 16'd100) < 16'd70;
      end
    end
  endtask

  task automatic wait_drained();
    while (exp_sts_q[0].size() != 0 || exp_sts_q[1].size() != 0) @(negedge clk_i);
    repeat (10) @(negedge clk_i);
  endtask

  // Stalls app 0 on a full genbits buffer, then fills its command FIFO.
  task automatic fill_test();
    hold_rdy[0] = 1'b1;
    send_command(0, csrng_pkg::INS, 4'd1, 13'd0);
    send_command(0, csrng_pkg::GEN, 4'd0, 13'd2);
    @(posedge clk_i);
    while (!genbits_vld_o[0]) @(posedge clk_i);
    @(negedge clk_i);
    send_command(0, csrng_pkg::INS, 4'd15, 13'd0);
    @(posedge clk_i);
    assert (!cmd_rdy_o[0]) else flag_mismatch("cmd_rdy_o high with 16 words queued");
    @(negedge clk_i);
    hold_rdy[0] = 1'b0;
    wait_drained();
  endtask

  // Header and one of two words, then enable drops.
  task automatic abort_test();
    push_word(0, 32'h0000_0021);
    push_word(0, lcg_next(0));
    repeat (8) @(negedge clk_i);
    enable_i = 1'b0;
    repeat (4) begin
      @(posedge clk_i);
      assert (!cmd_rdy_o[0] && !genbits_vld_o[0])
        else flag_mismatch("cmd_rdy_o or genbits_vld_o high while disabled");
    end
    @(negedge clk_i);
    enable_i = 1'b1;
    send_command(0, csrng_pkg::GEN, 4'd0, 13'd2);
    send_command(0, csrng_pkg::UPD, 4'd2, 13'd0);
    send_command(0, csrng_pkg::GEN, 4'd1, 13'd1);
    wait_drained();
  endtask

  // ------------------------------
  // Checkers.
  // ------------------------------
  initial begin : monitor
    logic         sts;
    int           mark;
    logic [128:0] blk;
    forever begin
      @(posedge clk_i);
      for (int a = 0; a < NumApps; a++) begin
        assert (fifo_err_o[a] == 6'd0)
          else flag_mismatch($sformatf("app %0d fifo_err_o %b", a, fifo_err_o[a]));
        if (genbits_vld_o[a] && genbits_rdy_i[a]) begin
          assert (exp_blk_q[a].size() != 0)
            else flag_problem($sformatf("app %0d delivered a block nobody asked for", a));
          if (exp_blk_q[a].size() != 0) begin
            blk = exp_blk_q[a].pop_front();
            blk_seen[a]++;
            assert ({genbits_fips_o[a], genbits_bus_o[a]} == blk)
              else flag_mismatch($sformatf("app %0d block %h, expected %h", a,
                                           {genbits_fips_o[a], genbits_bus_o[a]}, blk));
          end
        end
        if (cmd_ack_o[a]) begin
          acks_seen++;
          assert (exp_sts_q[a].size() != 0)
            else flag_problem($sformatf("app %0d gave an ack with no command pending", a));
          if (exp_sts_q[a].size() != 0) begin
            sts  = exp_sts_q[a].pop_front();
            mark = exp_mark_q[a].pop_front();
            assert (cmd_ack_sts_o[a] == sts)
              else flag_mismatch($sformatf("app %0d ack status %0b, expected %0b", a,
                                           cmd_ack_sts_o[a], sts));
            assert (blk_seen[a] == mark)
              else flag_mismatch($sformatf("app %0d ack after %0d blocks, expected %0d", a,
                                           blk_seen[a], mark));
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (ResetCycles + 200 * TotalCmds) @(posedge clk_i);
    $display("Timeout: the run did not finish in %0d cycles",
             ResetCycles + 200 * TotalCmds);
    $display("Commands: %0d, acks: %0d, value errors: %0d, other errors: %0d",
             cmds_issued, acks_seen, value_errs, other_errs);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    @(negedge clk_i);
    fork
      drive_genbits_ready(0);
      drive_genbits_ready(1);
    join
  end

  // ------------------------------
  // Main sequence.
  // ------------------------------
  initial begin : main
    rst_ni     = 1'b0;
    enable_i   = 1'b0;
    acks_seen  = 0;
    value_errs = 0;
    other_errs = 0;
    for (int a = 0; a < NumApps; a++) begin
      cmd_vld_i[a]     = 1'b0;
      cmd_bus_i[a]     = '0;
      genbits_rdy_i[a] = 1'b0;
      hold_rdy[a]      = 1'b0;
    end
    for (int s = 0; s < 2 * NumApps; s++) begin
      rng_q[s] = Seed + 32'(s);
    end
    reset_model();
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    for (int a = 0; a < NumApps; a++) begin
      assert (!cmd_rdy_o[a] && !genbits_vld_o[a] && !cmd_ack_o[a])
        else flag_mismatch($sformatf("app %0d outputs not low after reset", a));
    end
    @(negedge clk_i);
    enable_i = 1'b1;
    fork
      run_app(0);
      run_app(1);
    join
    wait_drained();
    fill_test();
    abort_test();
    for (int a = 0; a < NumApps; a++) begin
      assert (exp_blk_q[a].size() == 0)
        else flag_problem($sformatf("app %0d never delivered all blocks", a));
    end
    $display("Commands: %0d, acks: %0d, value errors: %0d, other errors: %0d",
             cmds_issued, acks_seen, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
